/* hdl/shm_switch_pkg.sv */
package shm_switch_pkg;

    // default sizes, the top level may override them
    localparam int NUM_PORTS_DEFAULT = 4;      // power of two
    localparam int DATA_W_DEFAULT    = 16;
    localparam int VOQ_DEPTH_DEFAULT = 8;      // power of two

    // header word layout
    // the destination port index sits in the low bits of the first word,
    // as wide as the port index of the switch
    localparam int DEST_LSB = 0;

    // a queue reports nearly full once its free entries drop to this margin,
    // which leaves room for the word still held in the ingress register
    localparam int FULL_MARGIN = 2;

endpackage

/* hdl/ingress_tagger.sv */
`timescale 1ns/100ps

module ingress_tagger #(
    parameter int NUM_PORTS = shm_switch_pkg::NUM_PORTS_DEFAULT,
    parameter int DATA_W    = shm_switch_pkg::DATA_W_DEFAULT,
    localparam int PORT_W   = $clog2(NUM_PORTS)
) (
    input  logic                clk,
    input  logic                arst_n,

    input  logic                wr_sop,
    input  logic                wr_eop,
    input  logic                wr_vld,
    input  logic [DATA_W-1:0]   wr_data,

    output logic                tag_vld,
    output logic                tag_sop,
    output logic                tag_eop,
    output logic [PORT_W-1:0]   tag_dest,
    output logic [DATA_W-1:0]   tag_data
);

    import shm_switch_pkg::*;

    logic [PORT_W-1:0] hdr_dest;

    assign hdr_dest = wr_data[DEST_LSB +: PORT_W];  // only meaningful on the header word

    // tag_dest doubles as the held destination, body words leave it untouched
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tag_vld  <= 1'b0;
            tag_sop  <= 1'b0;
            tag_eop  <= 1'b0;
            tag_dest <= '0;
        end else begin
            tag_vld <= wr_vld;
            tag_sop <= wr_vld && wr_sop;
            tag_eop <= wr_vld && wr_eop;
            if (wr_vld && wr_sop) begin
                tag_dest <= hdr_dest;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_vld) begin
            tag_data <= wr_data;  // header word goes through unchanged
        end
    end

endmodule

/* hdl/voq_fifo.sv */
`timescale 1ns/100ps

module voq_fifo #(
    parameter int WORD_W  = shm_switch_pkg::DATA_W_DEFAULT + 2,
    parameter int DEPTH   = shm_switch_pkg::VOQ_DEPTH_DEFAULT,
    localparam int PTR_W  = $clog2(DEPTH)
) (
    input  logic                clk,
    input  logic                arst_n,

    input  logic                push,
    input  logic [WORD_W-1:0]   push_word,
    input  logic                pop,

    output logic [WORD_W-1:0]   head_word,
    output logic                empty,
    output logic                nearly_full
);

    import shm_switch_pkg::*;

    localparam logic [PTR_W:0] DEPTH_CNT = (PTR_W+1)'(DEPTH);
    localparam logic [PTR_W:0] NF_LEVEL  = (PTR_W+1)'(DEPTH - FULL_MARGIN);

    logic [WORD_W-1:0] mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [PTR_W:0]    count;
    logic              full_q;
    logic              do_push;
    logic              do_pop;

    assign full_q  = (count == DEPTH_CNT);
    assign do_push = push && !full_q;   // a word sent into a full queue is dropped
    assign do_pop  = pop && !empty;

    assign empty       = (count == '0);
    assign nearly_full = (count >= NF_LEVEL);
    assign head_word   = mem[rd_ptr];   // head is visible without a read cycle

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_word;
        end
    end

    // pointers wrap on their own since DEPTH is a power of two
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* hdl/voq_array.sv */
`timescale 1ns/100ps

module voq_array #(
    parameter int NUM_PORTS = shm_switch_pkg::NUM_PORTS_DEFAULT,
    parameter int DATA_W    = shm_switch_pkg::DATA_W_DEFAULT,
    parameter int VOQ_DEPTH = shm_switch_pkg::VOQ_DEPTH_DEFAULT,
    localparam int PORT_W   = $clog2(NUM_PORTS)
) (
    input  logic                            clk,
    input  logic                            arst_n,

    // one lane per source
    input  logic [NUM_PORTS-1:0]            tag_vld,
    input  logic [NUM_PORTS-1:0]            tag_sop,
    input  logic [NUM_PORTS-1:0]            tag_eop,
    input  logic [NUM_PORTS*PORT_W-1:0]     tag_dest,
    input  logic [NUM_PORTS*DATA_W-1:0]     tag_data,

    // one lane per destination
    input  logic [NUM_PORTS-1:0]            rd_en,
    input  logic [NUM_PORTS*PORT_W-1:0]     rd_src,

    output logic [NUM_PORTS*NUM_PORTS-1:0]  q_empty,
    output logic [NUM_PORTS-1:0]            head_sop,
    output logic [NUM_PORTS-1:0]            head_eop,
    output logic [NUM_PORTS*DATA_W-1:0]     head_data,
    output logic                            full
);

    localparam int WORD_W = DATA_W + 2;  // {sop, eop, data}

    logic [WORD_W-1:0]              head_w [NUM_PORTS][NUM_PORTS];  // [source][destination]
    logic [NUM_PORTS*NUM_PORTS-1:0] nf_all;

    for (genvar s = 0; s < NUM_PORTS; s++) begin : g_src
        for (genvar d = 0; d < NUM_PORTS; d++) begin : g_dst
            logic push;
            logic pop;

            assign push = tag_vld[s] && (tag_dest[s*PORT_W +: PORT_W] == PORT_W'(d));
            assign pop  = rd_en[d] && (rd_src[d*PORT_W +: PORT_W] == PORT_W'(s));

            voq_fifo #(
                .WORD_W (WORD_W),
                .DEPTH  (VOQ_DEPTH)
            ) u_voq (
                .clk         (clk),
                .arst_n      (arst_n),
                .push        (push),
                .push_word   ({tag_sop[s], tag_eop[s], tag_data[s*DATA_W +: DATA_W]}),
                .pop         (pop),
                .head_word   (head_w[s][d]),
                .empty       (q_empty[d*NUM_PORTS + s]),  // grouped by destination column
                .nearly_full (nf_all[s*NUM_PORTS + d])
            );
        end
    end

    for (genvar d = 0; d < NUM_PORTS; d++) begin : g_rd
        logic [WORD_W-1:0] sel_word;

        assign sel_word = head_w[rd_src[d*PORT_W +: PORT_W]][d];

        assign head_sop[d]                   = sel_word[WORD_W-1];
        assign head_eop[d]                   = sel_word[WORD_W-2];
        assign head_data[d*DATA_W +: DATA_W] = sel_word[DATA_W-1:0];
    end

    // one slow queue pauses every sender
    assign full = |nf_all;

endmodule

/* hdl/egress_scheduler.sv */
`timescale 1ns/100ps

module egress_scheduler #(
    parameter int NUM_PORTS = shm_switch_pkg::NUM_PORTS_DEFAULT,
    parameter int DATA_W    = shm_switch_pkg::DATA_W_DEFAULT,
    localparam int PORT_W   = $clog2(NUM_PORTS)
) (
    input  logic                    clk,
    input  logic                    arst_n,

    input  logic                    ready,

    // column of queues that feed this output, bit s is source s
    input  logic [NUM_PORTS-1:0]    q_empty,
    input  logic                    head_sop,
    input  logic                    head_eop,
    input  logic [DATA_W-1:0]       head_data,

    output logic                    rd_en,
    output logic [PORT_W-1:0]       rd_src,

    output logic                    rd_sop,
    output logic                    rd_eop,
    output logic                    rd_vld,
    output logic [DATA_W-1:0]       rd_data
);

    logic [PORT_W-1:0] rr_ptr;
    logic [PORT_W-1:0] grant_src;
    logic              locked;
    logic [PORT_W-1:0] pick_src;

    // first non-empty queue at or after the pointer
    always_comb begin
        logic [PORT_W-1:0] idx;

        idx      = rr_ptr;
        pick_src = rr_ptr;
        for (int k = NUM_PORTS - 1; k >= 0; k--) begin
            idx = rr_ptr + PORT_W'(k);  // wraps since the port count is a power of two
            if (!q_empty[idx]) begin
                pick_src = idx;  // the lowest k is checked last and wins
            end
        end
    end

    assign rd_src = locked ? grant_src : pick_src;
    assign rd_en  = ready && !q_empty[rd_src];

    // packet lock, released by the eop word
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rr_ptr    <= '0;
            grant_src <= '0;
            locked    <= 1'b0;
        end else if (rd_en) begin
            if (head_eop) begin
                locked <= 1'b0;
                rr_ptr <= rd_src + PORT_W'(1);
            end else begin
                locked    <= 1'b1;
                grant_src <= rd_src;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_vld <= 1'b0;
            rd_sop <= 1'b0;
            rd_eop <= 1'b0;
        end else begin
            rd_vld <= rd_en;
            rd_sop <= rd_en && head_sop;
            rd_eop <= rd_en && head_eop;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= head_data;  // popped word shows up the cycle after rd_en
        end
    end

endmodule

/* hdl/shm_switch_top.sv */
`timescale 1ns/100ps

module shm_switch_top #(
    parameter int NUM_PORTS = shm_switch_pkg::NUM_PORTS_DEFAULT,
    parameter int DATA_W    = shm_switch_pkg::DATA_W_DEFAULT,
    parameter int VOQ_DEPTH = shm_switch_pkg::VOQ_DEPTH_DEFAULT,
    localparam int PORT_W   = $clog2(NUM_PORTS)
) (
    input  logic                            clk,
    input  logic                            arst_n,

    input  logic [NUM_PORTS-1:0]            wr_sop,
    input  logic [NUM_PORTS-1:0]            wr_eop,
    input  logic [NUM_PORTS-1:0]            wr_vld,
    input  logic [NUM_PORTS*DATA_W-1:0]     wr_data,

    output logic [NUM_PORTS-1:0]            rd_sop,
    output logic [NUM_PORTS-1:0]            rd_eop,
    output logic [NUM_PORTS-1:0]            rd_vld,
    output logic [NUM_PORTS*DATA_W-1:0]     rd_data,

    output logic                            full,
    input  logic [NUM_PORTS-1:0]            ready
);

    logic [NUM_PORTS-1:0]           tag_vld;
    logic [NUM_PORTS-1:0]           tag_sop;
    logic [NUM_PORTS-1:0]           tag_eop;
    logic [NUM_PORTS*PORT_W-1:0]    tag_dest;
    logic [NUM_PORTS*DATA_W-1:0]    tag_data;

    logic [NUM_PORTS-1:0]           rd_en;
    logic [NUM_PORTS*PORT_W-1:0]    rd_src;
    logic [NUM_PORTS*NUM_PORTS-1:0] q_empty;
    logic [NUM_PORTS-1:0]           head_sop;
    logic [NUM_PORTS-1:0]           head_eop;
    logic [NUM_PORTS*DATA_W-1:0]    head_data;

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
        ingress_tagger #(
            .NUM_PORTS (NUM_PORTS),
            .DATA_W    (DATA_W)
        ) u_tagger (
            .clk      (clk),
            .arst_n   (arst_n),
            .wr_sop   (wr_sop[i]),
            .wr_eop   (wr_eop[i]),
            .wr_vld   (wr_vld[i]),
            .wr_data  (wr_data[i*DATA_W +: DATA_W]),
            .tag_vld  (tag_vld[i]),
            .tag_sop  (tag_sop[i]),
            .tag_eop  (tag_eop[i]),
            .tag_dest (tag_dest[i*PORT_W +: PORT_W]),
            .tag_data (tag_data[i*DATA_W +: DATA_W])
        );

        egress_scheduler #(
            .NUM_PORTS (NUM_PORTS),
            .DATA_W    (DATA_W)
        ) u_sched (
            .clk       (clk),
            .arst_n    (arst_n),
            .ready     (ready[i]),
            .q_empty   (q_empty[i*NUM_PORTS +: NUM_PORTS]),  // column of output i
            .head_sop  (head_sop[i]),
            .head_eop  (head_eop[i]),
            .head_data (head_data[i*DATA_W +: DATA_W]),
            .rd_en     (rd_en[i]),
            .rd_src    (rd_src[i*PORT_W +: PORT_W]),
            .rd_sop    (rd_sop[i]),
            .rd_eop    (rd_eop[i]),
            .rd_vld    (rd_vld[i]),
            .rd_data   (rd_data[i*DATA_W +: DATA_W])
        );
    end

    voq_array #(
        .NUM_PORTS (NUM_PORTS),
        .DATA_W    (DATA_W),
        .VOQ_DEPTH (VOQ_DEPTH)
    ) u_voq_array (
        .clk       (clk),
        .arst_n    (arst_n),
        .tag_vld   (tag_vld),
        .tag_sop   (tag_sop),
        .tag_eop   (tag_eop),
        .tag_dest  (tag_dest),
        .tag_data  (tag_data),
        .rd_en     (rd_en),
        .rd_src    (rd_src),
        .q_empty   (q_empty),
        .head_sop  (head_sop),
        .head_eop  (head_eop),
        .head_data (head_data),
        .full      (full)
    );

endmodule

/* dv/tb_clkgen.sv */
`timescale 1ns/100ps

module tb_clkgen #(
    parameter int PERIOD     = 100,
    parameter int RST_CYCLES = 3
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;  // released half a cycle away from the rising edge
    end

endmodule

/* dv/shm_switch_tb.sv */
`timescale 1ns/100ps

module shm_switch_tb;

    import shm_switch_pkg::*;

    localparam int NUM_PORTS  = NUM_PORTS_DEFAULT;
    localparam int DATA_W     = DATA_W_DEFAULT;
    localparam int VOQ_DEPTH  = VOQ_DEPTH_DEFAULT;
    localparam int PORT_W     = $clog2(NUM_PORTS);
    localparam int WORD_W     = DATA_W + 2;
    localparam int CLK_PERIOD = 100;
    localparam int NF_LEVEL   = VOQ_DEPTH - FULL_MARGIN;
    // most words per test: unicast, contention, back-pressure, full, random
    localparam longint TOTAL_WORDS = 16 * 5 + 4 * 4 + 40 * 5 + 8 + 200 * 5;
    localparam longint WATCHDOG_NS = TOTAL_WORDS * 40 * CLK_PERIOD;

    logic                        clk, arst_n, full;
    logic [NUM_PORTS-1:0]        wr_sop, wr_eop, wr_vld, ready;
    logic [NUM_PORTS-1:0]        rd_sop, rd_eop, rd_vld, ready_seen;
    logic [NUM_PORTS*DATA_W-1:0] wr_data, rd_data;
    logic [NUM_PORTS-1:0]        ready_level = '1;
    logic                        rand_ready = 1'b0;

    logic [WORD_W-1:0] tx_q [NUM_PORTS][$];              // words waiting at each input
    logic [WORD_W-1:0] exp_q [NUM_PORTS*NUM_PORTS][$];   // scoreboard, source * N + dest
    int                in_switch [NUM_PORTS];             // words sent and not yet seen at an output
    int                cur_src [NUM_PORTS];
    bit                in_pkt [NUM_PORTS];
    int                arrive0 [$];                       // packet sources seen at output 0
    int                acc_cnt = 0;
    int                err_cnt = 0;

    tb_clkgen #(.PERIOD(CLK_PERIOD), .RST_CYCLES(3)) clkgen0 (.clk(clk), .arst_n(arst_n));

    shm_switch_top #(
        .NUM_PORTS (NUM_PORTS),
        .DATA_W    (DATA_W),
        .VOQ_DEPTH (VOQ_DEPTH)
    ) dut0 (
        .clk (clk), .arst_n (arst_n),
        .wr_sop (wr_sop), .wr_eop (wr_eop), .wr_vld (wr_vld), .wr_data (wr_data),
        .rd_sop (rd_sop), .rd_eop (rd_eop), .rd_vld (rd_vld), .rd_data (rd_data),
        .full (full), .ready (ready)
    );

    task automatic fail_run(input string why);
        err_cnt++;
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            fail_run($sformatf("MISMATCH at %0d ns: %s, got %0h, expected %0h",
                               $time, what, got, exp));
        end
    endtask

    // every word carries its source index just above the destination field
    task automatic enqueue_packet(input int src, input int dst, input int len);
        logic [DATA_W-1:0] d;
        logic [WORD_W-1:0] w;
        for (int k = 0; k < len; k++) begin
            d = DATA_W'($urandom);
            d[2*PORT_W-1:PORT_W] = PORT_W'(src);
            if (k == 0) begin
                d[DEST_LSB +: PORT_W] = PORT_W'(dst);
            end
            w = {k == 0, k == len - 1, d};
            tx_q[src].push_back(w);
            exp_q[src * NUM_PORTS + dst].push_back(w);
        end
    endtask

    // a new packet waits until its input has nothing left in the switch
    // so that a locked output never waits on a paused input
    function automatic bit can_send(input int s);
        if (tx_q[s].size() == 0) return 1'b0;
        return !(tx_q[s][0][WORD_W-1] && in_switch[s] != 0);
    endfunction

    function automatic bit traffic_pending();
        for (int s = 0; s < NUM_PORTS; s++) begin
            if (tx_q[s].size() != 0) return 1'b1;
        end
        for (int q = 0; q < NUM_PORTS * NUM_PORTS; q++) begin
            if (exp_q[q].size() != 0) return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic wait_drained();
        while (traffic_pending()) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
    endtask

    task automatic take_output_word(input int j);
        logic [DATA_W-1:0] data;
        logic [WORD_W-1:0] exp_w;
        int                src;
        int                qi;
        data = rd_data[j*DATA_W +: DATA_W];
        src  = int'(data[2*PORT_W-1:PORT_W]);
        qi   = src * NUM_PORTS + j;
        check_eq(32'(ready_seen[j]), 1, $sformatf("ready before a word on output %0d", j));
        if (in_pkt[j]) begin
            check_eq(src, cur_src[j], $sformatf("source inside a packet on output %0d", j));
        end
        if (exp_q[qi].size() == 0) begin
            fail_run($sformatf("output %0d sent a word from input %0d that nobody sent", j, src));
        end else begin
            exp_w = exp_q[qi].pop_front();
            in_switch[src]--;
            check_eq(32'({rd_sop[j], rd_eop[j], data}), 32'(exp_w),
                     $sformatf("word from input %0d on output %0d", src, j));
            if (rd_sop[j]) begin
                in_pkt[j]  = 1'b1;
                cur_src[j] = src;
                if (j == 0) arrive0.push_back(src);
            end
            if (rd_eop[j]) begin
                in_pkt[j] = 1'b0;
            end
        end
    endtask

    // outputs are checked first, then senders pause for the whole cycle whenever full is high
    initial begin : drive_inputs
        logic [WORD_W-1:0] w;
        wr_sop  = '0;
        wr_eop  = '0;
        wr_vld  = '0;
        wr_data = '0;
        ready   = '0;
        forever begin
            @(negedge clk);
            if (arst_n) begin
                for (int j = 0; j < NUM_PORTS; j++) begin
                    if (rd_vld[j]) take_output_word(j);
                end
            end
            wr_vld = '0;
            wr_sop = '0;
            wr_eop = '0;
            if (arst_n && !full) begin
                for (int s = 0; s < NUM_PORTS; s++) begin
                    if (can_send(s)) begin
                        w = tx_q[s].pop_front();
                        in_switch[s]++;
                        wr_vld[s] = 1'b1;
                        wr_sop[s] = w[WORD_W-1];
                        wr_eop[s] = w[WORD_W-2];
                        wr_data[s*DATA_W +: DATA_W] = w[DATA_W-1:0];
                    end
                end
            end
            ready = rand_ready ? NUM_PORTS'($urandom) : ready_level;
        end
    end

    always @(posedge clk) begin
        ready_seen <= ready;  // what the schedulers used at this edge
        if (wr_vld[0]) acc_cnt <= acc_cnt + 1;
    end

    task automatic reset_outputs_low();
        repeat (4) begin
            @(negedge clk);
            check_eq(32'(rd_vld), 0, "rd_vld after reset");
            check_eq(32'(full), 0, "full after reset");
        end
        @(posedge clk);
    endtask

    task automatic unicast_all_pairs();
        for (int s = 0; s < NUM_PORTS; s++) begin
            for (int d = 0; d < NUM_PORTS; d++) begin
                enqueue_packet(s, d, 1 + (s * NUM_PORTS + d) % 5);
                wait_drained();
            end
        end
    endtask

    // the last unicast packet on output 0 came from the top input, so its pointer is back at 0
    task automatic contention_on_port0();
        arrive0.delete();
        for (int s = 0; s < NUM_PORTS; s++) enqueue_packet(s, 0, 4);
        wait_drained();
        check_eq(arrive0.size(), NUM_PORTS, "packets delivered to output 0");
        for (int k = 0; k < NUM_PORTS; k++) begin
            check_eq(arrive0[k], k, "grant order on output 0");
        end
    endtask

    task automatic back_pressure_traffic();
        rand_ready = 1'b1;
        for (int p = 0; p < 40; p++) begin
            enqueue_packet(int'($urandom_range(NUM_PORTS - 1)),
                           int'($urandom_range(NUM_PORTS - 1)), 1 + int'($urandom_range(4)));
        end
        wait_drained();
        rand_ready = 1'b0;
    endtask

    task automatic full_on_stalled_port();
        int base;
        int prev;
        bit saw_full;
        ready_level[1] = 1'b0;
        repeat (2) @(posedge clk);
        base     = acc_cnt;
        prev     = base;
        saw_full = 1'b0;
        enqueue_packet(0, 1, 8);
        for (int c = 0; c < 14; c++) begin
            @(negedge clk);
            // the queue holds every word the tagger took before the last edge
            check_eq(32'(full), 32'((prev - base) >= NF_LEVEL), "full while output 1 stalls");
            saw_full |= full;
            prev = acc_cnt;
        end
        check_eq(32'(saw_full), 1, "full reached with output 1 stalled");
        @(posedge clk);
        ready_level[1] = 1'b1;
        wait_drained();
        @(negedge clk);
        check_eq(32'(full), 0, "full after output 1 drained");
        @(posedge clk);
    endtask

    task automatic random_traffic();
        for (int p = 0; p < 200; p++) begin
            enqueue_packet(int'($urandom_range(NUM_PORTS - 1)),
                           int'($urandom_range(NUM_PORTS - 1)), 1 + int'($urandom_range(4)));
        end
        wait_drained();
        @(negedge clk);
        check_eq(32'(full), 0, "full after random traffic");
        check_eq(32'(rd_vld), 0, "rd_vld after random traffic");
        @(posedge clk);
    endtask

    initial begin : watchdog
        #(WATCHDOG_NS);
        fail_run("watchdog expired before the traffic drained");
    end

    initial begin : run_tests
        void'($urandom(716));
        for (int j = 0; j < NUM_PORTS; j++) begin
            in_switch[j] = 0;
            cur_src[j]   = 0;
            in_pkt[j]    = 1'b0;
        end
        @(posedge arst_n);
        @(posedge clk);
        reset_outputs_low();
        unicast_all_pairs();
        contention_on_port0();
        back_pressure_traffic();
        full_on_stalled_port();
        random_traffic();
        if (err_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* shm_switch.f */
hdl/shm_switch_pkg.sv
hdl/ingress_tagger.sv
hdl/voq_fifo.sv
hdl/voq_array.sv
hdl/egress_scheduler.sv
hdl/shm_switch_top.sv
dv/tb_clkgen.sv
dv/shm_switch_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= shm_switch_tb
RTL_TOP    ?= shm_switch_top
FILELIST   ?= shm_switch.f
BUILD_DIR  ?= obj_dir
PASS_MSG   ?= ALL CHECKS PASSED
SIM_FLAGS  ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only -Wall
RTL_SRCS   ?= $(shell grep '^hdl/' $(FILELIST))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# the run passes only if the pass line shows up in the simulator output
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR)
